//--- design/sa_cfg.svh
/*
  array and datapath sizes for the weight-stationary accelerator
  ARRAY_DIM must be 2 or more, since the weight row select needs a bit
  results wrap modulo 2**PSUM_W, and PSUM_W must exceed ELEM_W
*/
`ifndef SA_CFG_SVH
`define SA_CFG_SVH

// rows and columns of the MAC grid
`define ARRAY_DIM 4

// signed input and weight element width
`define ELEM_W 8

// signed partial sum / result width
`define PSUM_W 24

`endif

//--- design/sa_drain.sv
/*
  output deskew and result register
  column j waits ARRAY_DIM-1-j cycles so all columns line up
  out_row holds the last result between strobes
*/
`timescale 1ns/1ps
`include "sa_cfg.svh"

module sa_drain (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  sa_types_pkg::psum_row_t col_sum,
  input  logic [`ARRAY_DIM-1:0]   col_vld,
  output logic                    out_valid,
  output sa_types_pkg::psum_row_t out_row
);

  localparam int N = `ARRAY_DIM;

  sa_types_pkg::psum_row_t al_sum;
  logic [N-1:0] al_vld;

  for (genvar j = 0; j < N; j++) begin : g_col
    localparam int D = N - 1 - j;

    // last column already arrives aligned
    if (D == 0) begin : g_pass
      assign al_sum[j] = col_sum[j];
      assign al_vld[j] = col_vld[j];
    end else begin : g_dly
      sa_types_pkg::psum_t sd [D];
      logic [D-1:0] vd;

      always_ff @(posedge CLK) begin
        if (!rst_n) begin
          vd <= '0;
        end else begin
          vd[0] <= col_vld[j];
          for (int s = 1; s < D; s++) begin
            vd[s] <= vd[s-1];
          end
        end
      end

      always_ff @(posedge CLK) begin
        sd[0] <= col_sum[j];
        for (int s = 1; s < D; s++) begin
          sd[s] <= sd[s-1];
        end
      end

      assign al_sum[j] = sd[D-1];
      assign al_vld[j] = vd[D-1];
    end
  end

  // final stage
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= al_vld[0];
    end
  end

  always_ff @(posedge CLK) begin
    if (al_vld[0]) begin
      out_row <= al_sum;
    end
  end

  // skew and deskew must cancel for every column
  a_cols_aligned: assert property (@(posedge CLK) disable iff (!rst_n)
    (al_vld == '0) || (al_vld == '1));

endmodule

//--- design/sa_feed_skew.sv
/*
  input and bias skew ahead of the array
  lane k is registered once, then delayed k more cycles
  x lane k feeds row k, bias lane k feeds column k
*/
`timescale 1ns/1ps
`include "sa_cfg.svh"

module sa_feed_skew (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  sa_types_pkg::feed_t     feed,
  output sa_types_pkg::elem_row_t x_edge,
  output logic [`ARRAY_DIM-1:0]   x_vld,
  output sa_types_pkg::psum_row_t b_edge,
  output logic [`ARRAY_DIM-1:0]   b_vld
);

  for (genvar k = 0; k < `ARRAY_DIM; k++) begin : g_lane
    // k+1 deep lines, stage 0 is the common entry register
    sa_types_pkg::elem_t xd [k+1];
    sa_types_pkg::psum_t bd [k+1];
    logic [k:0] vd;

    // valid walks alongside its data so rows can overlap
    always_ff @(posedge CLK) begin
      if (!rst_n) begin
        vd <= '0;
      end else begin
        vd[0] <= feed.valid;
        for (int s = 1; s <= k; s++) begin
          vd[s] <= vd[s-1];
        end
      end
    end

    always_ff @(posedge CLK) begin
      xd[0] <= feed.x[k];
      bd[0] <= feed.bias[k];
      for (int s = 1; s <= k; s++) begin
        xd[s] <= xd[s-1];
        bd[s] <= bd[s-1];
      end
    end

    // row k and column k share the same diagonal
    assign x_edge[k] = xd[k];
    assign x_vld[k] = vd[k];
    assign b_edge[k] = bd[k];
    assign b_vld[k] = vd[k];
  end

endmodule

//--- design/sa_system.sv
/*
  scratchpad command stream to systolic array, top level
  ISSUE sampled on one edge gives out_valid 2*ARRAY_DIM+1 edges later
  cmd_err pulses one edge after a refused command
*/
`timescale 1ns/1ps
`include "sa_cfg.svh"

module sa_system (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    cmd_valid,
  input  sp_cmd_pkg::sp_cmd_u     cmd,
  output logic                    out_valid,
  output sa_types_pkg::psum_row_t out_row,
  output logic                    cmd_err
);

  sa_types_pkg::feed_t     feed;
  sa_types_pkg::wload_t    wload;
  sa_types_pkg::elem_row_t x_edge;
  sa_types_pkg::psum_row_t b_edge;
  sa_types_pkg::psum_row_t col_sum;
  logic [`ARRAY_DIM-1:0]   x_vld, b_vld, col_vld;

  // decode, then skew, grid and drain
  sp_cmd_decode dec0 (
    .CLK(CLK), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
    .feed(feed), .wload(wload), .cmd_err(cmd_err)
  );

  sa_feed_skew skew0 (
    .CLK(CLK), .rst_n(rst_n), .feed(feed),
    .x_edge(x_edge), .x_vld(x_vld), .b_edge(b_edge), .b_vld(b_vld)
  );

  systolic_array sa0 (
    .CLK(CLK), .rst_n(rst_n), .wload(wload),
    .x_edge(x_edge), .x_vld(x_vld), .b_edge(b_edge), .b_vld(b_vld),
    .col_sum(col_sum), .col_vld(col_vld)
  );

  sa_drain drain0 (
    .CLK(CLK), .rst_n(rst_n), .col_sum(col_sum), .col_vld(col_vld),
    .out_valid(out_valid), .out_row(out_row)
  );

endmodule

//--- design/sa_types_pkg.sv
/*
  data types shared by the decode, skew, array and drain stages
  element 0 of every row sits in the low bits of the packed word
*/
`include "sa_cfg.svh"

package sa_types_pkg;

  // one signed operand
  typedef logic signed [`ELEM_W-1:0] elem_t;

  // one signed accumulator value
  typedef logic signed [`PSUM_W-1:0] psum_t;

  // weight row index
  typedef logic [$clog2(`ARRAY_DIM)-1:0] row_sel_t;

  // whole rows, element k at index k
  typedef elem_t [`ARRAY_DIM-1:0] elem_row_t;
  typedef psum_t [`ARRAY_DIM-1:0] psum_row_t;

  // decode to skew, one issued row with the bias it picked up
  typedef struct packed {
    logic      valid;
    elem_row_t x;
    psum_row_t bias;
  } feed_t;

  // weight write or clear, applied at the edge where it is seen
  typedef struct packed {
    logic                  en;
    row_sel_t              row_sel;
    elem_row_t             data;
    logic [`ARRAY_DIM-1:0] clear_mask;
  } wload_t;

endpackage

//--- design/sp_cmd_decode.sv
/*
  command decode stage, all outputs registered
  a weight load or clear is refused while any issued row is in flight
  one command per cycle at most, no back-pressure
*/
`timescale 1ns/1ps
`include "sa_cfg.svh"

module sp_cmd_decode (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 cmd_valid,
  input  sp_cmd_pkg::sp_cmd_u  cmd,
  output sa_types_pkg::feed_t  feed,
  output sa_types_pkg::wload_t wload,
  output logic                 cmd_err
);

  localparam int LAT = 2 * `ARRAY_DIM;
  localparam int CNT_W = $clog2(LAT + 1);

  logic do_issue, do_loadb, do_loadw, do_clear, bad_cmd, busy;
  logic [CNT_W-1:0] inflight_q;
  logic [LAT-1:0] issue_pipe;
  sa_types_pkg::psum_row_t bias_q;

  // registered outputs
  logic feed_vld_q;
  sa_types_pkg::elem_row_t feed_x_q;
  sa_types_pkg::psum_row_t feed_b_q;
  logic wl_en_q;
  logic [`ARRAY_DIM-1:0] wl_mask_q;
  sa_types_pkg::row_sel_t wl_row_q;
  sa_types_pkg::elem_row_t wl_data_q;

  assign busy = (inflight_q != '0);

  // op lives in the same bits in both views
  always_comb begin
    do_issue = 1'b0;
    do_loadb = 1'b0;
    do_loadw = 1'b0;
    do_clear = 1'b0;
    bad_cmd  = 1'b0;
    if (cmd_valid) begin
      case (cmd.row.op)
        sp_cmd_pkg::NOP: ;
        sp_cmd_pkg::LOAD_W: begin
          bad_cmd  = busy;
          do_loadw = !busy;
        end
        sp_cmd_pkg::LOAD_B: do_loadb = 1'b1;
        sp_cmd_pkg::ISSUE: do_issue = 1'b1;
        sp_cmd_pkg::CLEAR: begin
          bad_cmd  = busy;
          do_clear = !busy;
        end
        // reserved codes
        default: bad_cmd = 1'b1;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      feed_vld_q <= 1'b0;
      wl_en_q    <= 1'b0;
      wl_mask_q  <= '0;
      cmd_err    <= 1'b0;
      bias_q     <= '0;
      inflight_q <= '0;
      issue_pipe <= '0;
    end else begin
      feed_vld_q <= do_issue;
      wl_en_q    <= do_loadw;
      wl_mask_q  <= do_clear ? cmd.ctl.clear_mask : '0;
      cmd_err    <= bad_cmd;
      // row leaves the drain LAT cycles after it entered the count
      issue_pipe <= {issue_pipe[LAT-2:0], do_issue};
      inflight_q <= inflight_q + CNT_W'(do_issue) - CNT_W'(issue_pipe[LAT-1]);
      if (do_loadb) begin
        // sign extend each element into the accumulator width
        for (int k = 0; k < `ARRAY_DIM; k++) begin
          bias_q[k] <= {{(`PSUM_W - `ELEM_W){cmd.row.data[k][`ELEM_W-1]}}, cmd.row.data[k]};
        end
      end
    end
  end

  // payload
  always_ff @(posedge CLK) begin
    if (do_issue) begin
      feed_x_q <= cmd.row.data;
      feed_b_q <= bias_q;
    end
    if (do_loadw) begin
      wl_row_q  <= cmd.row.row_sel;
      wl_data_q <= cmd.row.data;
    end
  end

  assign feed.valid = feed_vld_q;
  assign feed.x = feed_x_q;
  assign feed.bias = feed_b_q;
  assign wload.en = wl_en_q;
  assign wload.row_sel = wl_row_q;
  assign wload.data = wl_data_q;
  assign wload.clear_mask = wl_mask_q;

  // an error and an accepted issue come from distinct commands
  a_err_vs_issue: assert property (@(posedge CLK) disable iff (!rst_n)
    !(cmd_err && feed.valid));

  // at most one issue per cycle over the pipeline latency
  a_inflight_max: assert property (@(posedge CLK) disable iff (!rst_n)
    inflight_q <= CNT_W'(LAT));

endmodule

//--- design/sp_cmd_pkg.sv
/*
  scratchpad command word
  op always sits in the top bits, so it can be read through either view
  codes 5 to 7 are reserved and rejected by decode
*/
`include "sa_cfg.svh"

package sp_cmd_pkg;

  typedef enum logic [2:0] {
    NOP    = 3'd0,
    LOAD_W = 3'd1,
    LOAD_B = 3'd2,
    ISSUE  = 3'd3,
    CLEAR  = 3'd4
  } opcode_e;

  // LOAD_W, LOAD_B and ISSUE
  typedef struct packed {
    opcode_e                 op;
    sa_types_pkg::row_sel_t  row_sel;
    sa_types_pkg::elem_row_t data;
  } row_cmd_t;

  // CLEAR, one mask bit per weight row
  // pad fills the word up to the row view width
  typedef struct packed {
    opcode_e                 op;
    logic [`ARRAY_DIM-1:0]   clear_mask;
    logic [$bits(sa_types_pkg::row_sel_t) + $bits(sa_types_pkg::elem_row_t)
           - `ARRAY_DIM - 1:0] pad;
  } ctl_cmd_t;

  // the same word, decoded by opcode
  typedef union packed {
    row_cmd_t row;
    ctl_cmd_t ctl;
  } sp_cmd_u;

endpackage

//--- design/systolic_array.sv
/*
  ARRAY_DIM x ARRAY_DIM weight-stationary MAC grid
  x moves right and partial sums move down, one cell per cycle
  sums wrap modulo 2**PSUM_W
  weights may only change while no row is inside the grid
*/
`timescale 1ns/1ps
`include "sa_cfg.svh"

module systolic_array (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  sa_types_pkg::wload_t    wload,
  input  sa_types_pkg::elem_row_t x_edge,
  input  logic [`ARRAY_DIM-1:0]   x_vld,
  input  sa_types_pkg::psum_row_t b_edge,
  input  logic [`ARRAY_DIM-1:0]   b_vld,
  output sa_types_pkg::psum_row_t col_sum,
  output logic [`ARRAY_DIM-1:0]   col_vld
);

  localparam int N = `ARRAY_DIM;

  // one bit per cell, set while it holds live data
  logic [N*N-1:0] busy_vec;

  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      sa_types_pkg::elem_t w_q;
      sa_types_pkg::elem_t x_q;
      sa_types_pkg::elem_t x_in;
      sa_types_pkg::psum_t p_q;
      sa_types_pkg::psum_t p_in;
      logic xv_q, pv_q, xv_in, pv_in;

      // x from the west edge or the left neighbour
      if (j == 0) begin : g_west
        assign x_in = x_edge[i];
        assign xv_in = x_vld[i];
      end else begin : g_inner_x
        assign x_in = g_row[i].g_col[j-1].x_q;
        assign xv_in = g_row[i].g_col[j-1].xv_q;
      end

      // partial sum from the bias edge or the cell above
      if (i == 0) begin : g_north
        assign p_in = b_edge[j];
        assign pv_in = b_vld[j];
      end else begin : g_inner_p
        assign p_in = g_row[i-1].g_col[j].p_q;
        assign pv_in = g_row[i-1].g_col[j].pv_q;
      end

      // whole-row write wins over a clear of the same row
      always_ff @(posedge CLK) begin
        if (!rst_n) begin
          w_q <= '0;
        end else if (wload.en && wload.row_sel == i) begin
          w_q <= wload.data[j];
        end else if (wload.clear_mask[i]) begin
          w_q <= '0;
        end
      end

      always_ff @(posedge CLK) begin
        if (!rst_n) begin
          xv_q <= 1'b0;
          pv_q <= 1'b0;
        end else begin
          xv_q <= xv_in;
          pv_q <= pv_in & xv_in;
        end
      end

      // operands widen to PSUM_W signed before the multiply
      always_ff @(posedge CLK) begin
        x_q <= x_in;
        p_q <= p_in + x_in * w_q;
      end

      assign busy_vec[i*N+j] = xv_q | pv_q;

      if (i == N - 1) begin : g_south
        assign col_sum[j] = p_q;
        assign col_vld[j] = pv_q;
      end
    end
  end

  // decode holds weight traffic back until the grid has emptied
  a_wload_idle: assert property (@(posedge CLK) disable iff (!rst_n)
    (wload.en || (|wload.clear_mask)) |-> !(|busy_vec));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the sa_system testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module sa_system_tb -f sa_system.f

# a failed run may exit nonzero, keep its output for the search below
sim_out=$(./obj_dir/Vsa_system_tb) || true
echo "$sim_out"

echo "$sim_out" | grep -q "^ALL CHECKS PASSED$"

//--- sa_system.f
+incdir+design
design/sa_types_pkg.sv
design/sp_cmd_pkg.sv
design/sp_cmd_decode.sv
design/sa_feed_skew.sv
design/systolic_array.sv
design/sa_drain.sv
design/sa_system.sv
tests/sa_system_tb.sv

//--- tests/sa_system_tb.sv
/*
  testbench for sa_system
  each table step is one command, optional random data, then idle cycles
  expected rows come from a software model of the weights and bias
  the table literals assume ARRAY_DIM of 4 and ELEM_W of 8
  outputs are checked on every falling edge once reset is released
*/
`timescale 1ns/1ps
`include "sa_cfg.svh"

module sa_system_tb;

  localparam int N = `ARRAY_DIM;
  // ISSUE driven at falling edge c shows out_valid at falling edge c + 2N + 2
  localparam int OUT_DLY = 2 * N + 2;
  localparam int RST_CYCLES = 16;
  localparam logic [2:0] OP_NOP = sp_cmd_pkg::NOP;
  localparam logic [2:0] OP_LW = sp_cmd_pkg::LOAD_W;
  localparam logic [2:0] OP_LB = sp_cmd_pkg::LOAD_B;
  localparam logic [2:0] OP_IS = sp_cmd_pkg::ISSUE;
  localparam logic [2:0] OP_CL = sp_cmd_pkg::CLEAR;

  // one table row, data low bits double as the CLEAR mask
  typedef struct packed {
    logic [3:0]              test;
    logic [2:0]              op;
    sa_types_pkg::row_sel_t  sel;
    sa_types_pkg::elem_row_t data;
    logic                    rnd;
    logic                    err;
    logic [7:0]              idle;
  } step_t;

  logic CLK;
  logic rst_n;
  logic cmd_valid;
  logic out_valid;
  logic cmd_err;
  sp_cmd_pkg::sp_cmd_u cmd;
  sa_types_pkg::psum_row_t out_row;

  step_t stim[$];
  integer seed;
  int cyc = 0;
  int cycle_limit;
  bit table_ready = 1'b0;
  int n_checks, n_errors, t_checks, t_errors;

  // reference model state and expectations with their due cycle
  sa_types_pkg::elem_row_t w_mdl [N];
  sa_types_pkg::psum_row_t bias_mdl;
  sa_types_pkg::psum_row_t row_exp[$];
  int row_due[$];
  int err_due[$];

  sa_system dut0 (
    .CLK(CLK), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
    .out_valid(out_valid), .out_row(out_row), .cmd_err(cmd_err)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  initial begin : watchdog
    wait (table_ready);
    wait (cyc >= cycle_limit);
    $display("timeout: run still going after %0d cycles", cyc);
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic string test_title(input int t);
    case (t)
      1: return "idle after reset";
      2: return "identity weights";
      3: return "random back to back";
      4: return "bias change between issues";
      5: return "weight update while busy";
      6: return "reserved opcodes";
      default: return "unknown";
    endcase
  endfunction

  // out[j] = bias[j] + sum x[i]*W[i][j], wrapped to PSUM_W bits
  function automatic sa_types_pkg::psum_row_t expected_row(input sa_types_pkg::elem_row_t x);
    sa_types_pkg::psum_row_t r;
    logic signed [31:0] acc;
    for (int j = 0; j < N; j++) begin
      acc = bias_mdl[j];
      for (int i = 0; i < N; i++) begin
        acc = acc + x[i] * w_mdl[i][j];
      end
      r[j] = acc[`PSUM_W-1:0];
    end
    return r;
  endfunction

  task automatic add_step(input int t, input logic [2:0] op, input int sel,
                          input sa_types_pkg::elem_row_t data, input bit rnd,
                          input bit err, input int idle);
    step_t s;
    s.test = 4'(t);
    s.op = op;
    s.sel = sa_types_pkg::row_sel_t'(sel);
    s.data = data;
    s.rnd = rnd;
    s.err = err;
    s.idle = 8'(idle);
    stim.push_back(s);
  endtask

  task automatic build_table();
    add_step(1, OP_NOP, 0, 32'h0, 0, 0, 10);
    add_step(1, OP_IS, 0, 32'h7f80_0102, 0, 0, 0);
    // identity matrix, one row at a time
    add_step(2, OP_LW, 0, 32'h0000_0001, 0, 0, 0);
    add_step(2, OP_LW, 1, 32'h0000_0100, 0, 0, 0);
    add_step(2, OP_LW, 2, 32'h0001_0000, 0, 0, 0);
    add_step(2, OP_LW, 3, 32'h0100_0000, 0, 0, 0);
    add_step(2, OP_IS, 0, 32'h807f_05fb, 0, 0, 0);
    add_step(2, OP_IS, 0, 32'h0, 1, 0, 0);
    add_step(2, OP_IS, 0, 32'hff01_40c0, 0, 0, 0);
    add_step(3, OP_LW, 0, 32'h0, 1, 0, 0);
    add_step(3, OP_LW, 1, 32'h0, 1, 0, 0);
    add_step(3, OP_LW, 2, 32'h0, 1, 0, 0);
    add_step(3, OP_LW, 3, 32'h0, 1, 0, 0);
    add_step(3, OP_LB, 0, 32'h0, 1, 0, 0);
    add_step(3, OP_IS, 0, 32'h0, 1, 0, 0);
    add_step(3, OP_IS, 0, 32'h0, 1, 0, 0);
    add_step(3, OP_IS, 0, 32'h0, 1, 0, 0);
    // 8 idle cycles is the shortest gap that lets a weight load in
    add_step(3, OP_IS, 0, 32'h0, 1, 0, 8);
    add_step(3, OP_LW, 0, 32'h8080_8080, 0, 0, 0);
    add_step(3, OP_LW, 1, 32'h8080_8080, 0, 0, 0);
    add_step(3, OP_LW, 2, 32'h8080_8080, 0, 0, 0);
    add_step(3, OP_LW, 3, 32'h8080_8080, 0, 0, 0);
    add_step(3, OP_LB, 0, 32'h7f80_7f80, 0, 0, 0);
    add_step(3, OP_IS, 0, 32'h8080_8080, 0, 0, 0);
    add_step(3, OP_IS, 0, 32'h7f7f_7f7f, 0, 0, 0);
    add_step(4, OP_LB, 0, 32'h0403_0201, 0, 0, 0);
    add_step(4, OP_IS, 0, 32'h0, 1, 0, 0);
    add_step(4, OP_LB, 0, 32'h80ff_fefd, 0, 0, 0);
    add_step(4, OP_IS, 0, 32'h0, 1, 0, 0);
    add_step(4, OP_IS, 0, 32'h0, 1, 0, 0);
    add_step(5, OP_IS, 0, 32'h0, 1, 0, 0);
    add_step(5, OP_LW, 1, 32'h1122_3344, 0, 1, 0);
    add_step(5, OP_CL, 0, 32'h0000_000f, 0, 1, 0);
    add_step(5, OP_IS, 0, 32'h0, 1, 0, 8);
    add_step(5, OP_LW, 1, 32'h1122_3344, 0, 0, 0);
    // rows 0 and 2 only
    add_step(5, OP_CL, 0, 32'h0000_0005, 0, 0, 0);
    add_step(5, OP_IS, 0, 32'h0, 1, 0, 0);
    add_step(5, OP_IS, 0, 32'h7f7f_7f7f, 0, 0, 0);
    add_step(6, 3'd5, 0, 32'h0, 1, 1, 0);
    add_step(6, 3'd7, 0, 32'h0, 1, 1, 0);
    add_step(6, 3'd6, 2, 32'h0, 1, 1, 10);
    add_step(6, OP_IS, 0, 32'h0, 1, 0, 0);
  endtask

  task automatic count_error();
    n_errors++;
    t_errors++;
  endtask

  // two checks per cycle, out_valid/out_row and cmd_err
  task automatic check_outputs();
    n_checks = n_checks + 2;
    t_checks = t_checks + 2;
    if (row_due.size() > 0 && row_due[0] == cyc) begin
      assert (out_valid === 1'b1 && out_row === row_exp[0]) else begin
        $display("FAIL %0t: out_row %h valid %b, expected %h", $time, out_row,
                 out_valid, row_exp[0]);
        count_error();
      end
      void'(row_due.pop_front());
      void'(row_exp.pop_front());
    end else begin
      assert (out_valid === 1'b0) else begin
        $display("FAIL %0t: out_valid high with no row due", $time);
        count_error();
      end
    end
    if (err_due.size() > 0 && err_due[0] == cyc) begin
      assert (cmd_err === 1'b1) else begin
        $display("FAIL %0t: cmd_err low for a refused command", $time);
        count_error();
      end
      void'(err_due.pop_front());
    end else begin
      assert (cmd_err === 1'b0) else begin
        $display("FAIL %0t: cmd_err high with no error due", $time);
        count_error();
      end
    end
  endtask

  task automatic next_cycle();
    @(negedge CLK);
    check_outputs();
    cmd_valid = 1'b0;
  endtask

  // drive one command and update the model the way the rules say
  task automatic apply_step(input step_t s);
    sa_types_pkg::elem_row_t d;
    logic signed [31:0] ext;
    d = s.data;
    if (s.rnd) begin
      d = $random(seed);
    end
    cmd = '0;
    if (s.op == OP_CL) begin
      cmd.ctl.op = sp_cmd_pkg::CLEAR;
      cmd.ctl.clear_mask = d[0][N-1:0];
    end else begin
      cmd.row.op = sp_cmd_pkg::opcode_e'(s.op);
      cmd.row.row_sel = s.sel;
      cmd.row.data = d;
    end
    cmd_valid = 1'b1;
    case (s.op)
      OP_LW: if (!s.err) w_mdl[s.sel] = d;
      OP_LB: begin
        // sign extension of each element
        for (int k = 0; k < N; k++) begin
          ext = d[k];
          bias_mdl[k] = ext[`PSUM_W-1:0];
        end
      end
      OP_IS: begin
        row_exp.push_back(expected_row(d));
        row_due.push_back(cyc + OUT_DLY);
      end
      OP_CL: begin
        for (int k = 0; k < N; k++) begin
          if (!s.err && d[0][k]) w_mdl[k] = '0;
        end
      end
      default: ;
    endcase
    // refused command, strobe right after the sampling edge
    if (s.err) begin
      err_due.push_back(cyc + 1);
    end
  endtask

  task automatic finish_test(input int t);
    while (row_due.size() > 0 || err_due.size() > 0) begin
      next_cycle();
    end
    $display("test %0d %s: %0d checks, %0d errors", t, test_title(t), t_checks, t_errors);
    t_checks = 0;
    t_errors = 0;
  endtask

  initial begin : main
    seed = 32'h648a3c41;
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd = '0;
    n_checks = 0;
    n_errors = 0;
    t_checks = 0;
    t_errors = 0;
    bias_mdl = '0;
    for (int i = 0; i < N; i++) begin
      w_mdl[i] = '0;
    end
    build_table();
    cycle_limit = stim.size() * (2 * N + 4) + RST_CYCLES;
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    for (int n = 0; n < stim.size(); n++) begin
      next_cycle();
      apply_step(stim[n]);
      repeat (stim[n].idle) next_cycle();
      // test ends where the next step belongs to another test
      if (n == stim.size() - 1 || stim[n + 1].test != stim[n].test) begin
        finish_test(stim[n].test);
      end
    end
    $display("total: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
